// File: logic/modem_pkg.sv
// address map, register offsets and timing constants shared by the host-side blocks
package modem_pkg;

  // ******************************
  // bus and pin widths
  // ******************************
  localparam int DATA_W   = 16;
  localparam int ADDR_W   = 12;            // byte address, pins carry 11..1
  localparam int SAMPLE_W = 14;            // adc and dac sample width
  localparam int N_DAC    = 3;
  localparam int SEL_W    = $clog2(N_DAC); // dac select field
  localparam int GPIO_W   = 2;             // two lock indicators

  // address fields
  localparam int SPACE_LSB = 8;            // space in addr[11:8]
  localparam int REG_LSB   = 1;            // register offset in addr[3:1]
  localparam int REG_W     = 3;

  // address spaces
  typedef enum logic [3:0] {
    MISC    = 4'd8,
    DAC_SER = 4'd9,
    GPIO    = 4'd10,
    NONE    = 4'd15
  } space_e;

  // ******************************
  // register offsets
  // ******************************
  localparam logic [REG_W-1:0] REG_RESET    = 3'd0; // misc space
  localparam logic [REG_W-1:0] REG_VERSION  = 3'd1;
  localparam logic [REG_W-1:0] REG_GPIO     = 3'd0; // gpio space
  localparam logic [REG_W-1:0] REG_DAC_WORD = 3'd0; // serial port space
  localparam logic [REG_W-1:0] REG_DAC_CTRL = 3'd1;

  localparam logic [DATA_W-1:0] VERSION = 16'h0003;

  // timing
  localparam int RESET_HOLD = 6;   // internal reset stretch after a software reset
  localparam int HOLD_W     = $clog2(RESET_HOLD + 1);
  localparam int SCLK_DIV   = 4;   // serial clock is ck933 / 4
  localparam int PHASE_W    = $clog2(SCLK_DIV);
  localparam int DAC_BITS   = 16;  // serial word length
  localparam int BIT_W      = $clog2(DAC_BITS);

endpackage

// File: logic/host_bus_if.sv
// decoded processor bus writes, driven by the address decoder and read by the register blocks
`timescale 1ns/1ns

interface host_bus_if;
  import modem_pkg::*;

  logic [ADDR_W-1:0] addr;   // byte address, bit 0 always zero
  logic [DATA_W-1:0] wdata;
  logic              wr;     // high on every edge with cs and we low
  space_e            space;  // decoded from addr[11:8]

  modport decoder (
    output addr,
    output wdata,
    output wr,
    output space
  );

  modport target (
    input addr,
    input wdata,
    input wr,
    input space
  );

endinterface

// File: logic/host_decode.sv
// processor bus front end: decodes the address space, forms the write strobe, muxes read data
`timescale 1ns/1ns

module host_decode (
  input  logic                          ck933,
  input  logic                          cs_n_i,
  input  logic                          we_n_i,
  input  logic                          rd_n_i,
  input  logic [modem_pkg::ADDR_W-1:1]  addr_i,
  input  logic [modem_pkg::DATA_W-1:0]  wdata_i,
  input  logic [modem_pkg::DATA_W-1:0]  misc_rdata_i,
  input  logic [modem_pkg::DATA_W-1:0]  dac_rdata_i,
  output logic [modem_pkg::DATA_W-1:0]  rdata_o,
  output logic                          rd_en_o,
  host_bus_if.decoder                   bus
);
  import modem_pkg::*;

  logic [ADDR_W-1:0] addr;

  assign addr = {addr_i, 1'b0}; // 16-bit bus, even bytes only

  assign bus.addr  = addr;
  assign bus.wdata = wdata_i;
  assign bus.wr    = ~cs_n_i & ~we_n_i; // level strobe, one write per clock
  assign rd_en_o   = ~cs_n_i & ~rd_n_i;

  // ******************************
  // space decode
  // ******************************
  always_comb begin
    case (addr[ADDR_W-1:SPACE_LSB])
      4'd8:    bus.space = MISC;
      4'd9:    bus.space = DAC_SER;
      4'd10:   bus.space = GPIO;
      default: bus.space = NONE;
    endcase
  end

  // ******************************
  // read data mux
  // ******************************
  // misc_regs answers for both the misc and gpio spaces
  always_comb begin
    case (bus.space)
      MISC,
      GPIO:    rdata_o = misc_rdata_i;
      DAC_SER: rdata_o = dac_rdata_i;
      default: rdata_o = '0; // unmapped
    endcase
  end

  // the processor never drives we and rd together, otherwise data_io
  // would be driven from both sides while a register takes the write
  wr_rd_excl_a : assert property (@(posedge ck933) !(bus.wr && rd_en_o))
    else $error("host bus write and read enable high in the same cycle");

endmodule

// File: logic/misc_regs.sv
// version register, software reset stretcher and the gpio lock register behind the host bus
`timescale 1ns/1ns

module misc_regs (
  input  logic                          ck933,
  input  logic                          rs,
  host_bus_if.target                    bus,
  output logic [modem_pkg::DATA_W-1:0]  rdata_o,
  output logic                          int_rs_o,
  output logic [modem_pkg::GPIO_W-1:0]  gpio_o
);
  import modem_pkg::*;

  logic [REG_W-1:0]  reg_off;
  logic              reset_wr;
  logic              gpio_wr;
  logic [HOLD_W-1:0] hold_cnt_q;
  logic [GPIO_W-1:0] gpio_q;

  assign reg_off  = bus.addr[REG_LSB+REG_W-1:REG_LSB];
  assign reset_wr = bus.wr && (bus.space == MISC) && (reg_off == REG_RESET);
  assign gpio_wr  = bus.wr && (bus.space == GPIO) && (reg_off == REG_GPIO);

  // ******************************
  // software reset
  // ******************************
  // written value is don't care, any write starts the stretch
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      hold_cnt_q <= '0;
    end else if (reset_wr) begin
      hold_cnt_q <= HOLD_W'(RESET_HOLD);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  // board reset passes straight through, software reset is stretched
  assign int_rs_o = rs | (hold_cnt_q != '0);

  // ******************************
  // gpio
  // ******************************
  always_ff @(posedge ck933 or posedge int_rs_o) begin
    if (int_rs_o) begin
      gpio_q <= '0;
    end else if (gpio_wr) begin
      gpio_q <= bus.wdata[GPIO_W-1:0];
    end
  end

  assign gpio_o = gpio_q; // bit 0 bsync lock, bit 1 demod lock

  // read back
  always_comb begin
    rdata_o = '0;
    case (bus.space)
      MISC: if (reg_off == REG_VERSION) rdata_o = VERSION;
      GPIO: if (reg_off == REG_GPIO) rdata_o = DATA_W'(gpio_q);
      default: rdata_o = '0;
    endcase
  end

  // a stretched reset must cover the full hold time seen by the serial port
  rst_hold_a : assert property (@(posedge ck933)
      $fell(int_rs_o) |-> $past(int_rs_o, RESET_HOLD))
    else $error("internal reset shorter than %0d cycles", RESET_HOLD);

endmodule

// File: logic/dac_serial_port.sv
// serial configuration port: shifts a 16-bit word MSB first to one of the three DACs
`timescale 1ns/1ns

module dac_serial_port (
  input  logic                          ck933,
  input  logic                          int_rs_i,
  host_bus_if.target                    bus,
  output logic [modem_pkg::DATA_W-1:0]  rdata_o,
  output logic                          sclk_o,
  output logic                          sdio_o,
  output logic [modem_pkg::N_DAC-1:0]   cs_n_o
);
  import modem_pkg::*;

  logic [REG_W-1:0]    reg_off;
  logic                word_wr;
  logic                ctrl_wr;
  logic                start;
  logic [SEL_W-1:0]    sel_q;      // select register, software view
  logic [SEL_W-1:0]    act_sel_q;  // select of the running transfer
  logic                busy_q;
  logic                sclk_q;
  logic [PHASE_W-1:0]  phase_q;    // position inside one bit
  logic [BIT_W-1:0]    bit_cnt_q;
  logic [DAC_BITS-1:0] shift_q;
  logic                bit_end;

  assign reg_off = bus.addr[REG_LSB+REG_W-1:REG_LSB];
  assign word_wr = bus.wr && (bus.space == DAC_SER) && (reg_off == REG_DAC_WORD);
  assign ctrl_wr = bus.wr && (bus.space == DAC_SER) && (reg_off == REG_DAC_CTRL);
  assign start   = word_wr && !busy_q; // words written while busy are dropped
  assign bit_end = (phase_q == PHASE_W'(SCLK_DIV - 1));

  always_ff @(posedge ck933 or posedge int_rs_i) begin
    if (int_rs_i) begin
      sel_q <= '0;
    end else if (ctrl_wr) begin
      sel_q <= bus.wdata[SEL_W-1:0];
    end
  end

  // ******************************
  // transfer sequencer
  // ******************************
  always_ff @(posedge ck933 or posedge int_rs_i) begin
    if (int_rs_i) begin
      busy_q    <= 1'b0;
      act_sel_q <= '0;
      sclk_q    <= 1'b0;
      phase_q   <= '0;
      bit_cnt_q <= '0;
    end else if (start) begin
      busy_q    <= 1'b1;
      act_sel_q <= sel_q;
      sclk_q    <= 1'b0;
      phase_q   <= '0;
      bit_cnt_q <= '0;
    end else if (busy_q) begin
      phase_q <= phase_q + 1'b1;
      if (phase_q == PHASE_W'(SCLK_DIV / 2 - 1)) begin
        sclk_q <= 1'b1; // rising edge mid bit, data is stable
      end
      if (bit_end) begin
        sclk_q    <= 1'b0;
        bit_cnt_q <= bit_cnt_q + 1'b1;
        if (bit_cnt_q == BIT_W'(DAC_BITS - 1)) begin
          busy_q <= 1'b0; // last bit done, cs releases with busy
        end
      end
    end
  end

  // data register, advances while the clock is low
  always_ff @(posedge ck933) begin
    if (start) begin
      shift_q <= bus.wdata;
    end else if (busy_q && bit_end) begin
      shift_q <= {shift_q[DAC_BITS-2:0], 1'b0};
    end
  end

  assign sclk_o = sclk_q;
  assign sdio_o = busy_q & shift_q[DAC_BITS-1]; // idle low

  // one active-low select per dac, select codes past N_DAC-1 reach none
  always_comb begin
    for (int i = 0; i < N_DAC; i++) begin
      cs_n_o[i] = !(busy_q && (act_sel_q == SEL_W'(i)));
    end
  end

  // status, busy in bit 15
  always_comb begin
    rdata_o = '0;
    if (reg_off == REG_DAC_CTRL) begin
      rdata_o[DATA_W-1]  = busy_q;
      rdata_o[SEL_W-1:0] = sel_q;
    end
  end

  // ******************************
  // checks
  // ******************************
  cs_onehot_a : assert property (@(posedge ck933) disable iff (int_rs_i)
      $onehot0(~cs_n_o))
    else $error("more than one dac chip select active");

  sclk_idle_a : assert property (@(posedge ck933) disable iff (int_rs_i)
      !busy_q |-> !sclk_o)
    else $error("serial clock high while port idle");

endmodule

// File: logic/adc_monitor.sv
// adc reclock and offset-binary formatting for the dac0 parallel monitor port
`timescale 1ns/1ns

module adc_monitor (
  input  logic                            ck933,
  input  logic [modem_pkg::SAMPLE_W-1:0]  adc_d_i,
  output logic [modem_pkg::SAMPLE_W-1:0]  dac0_d_o
);
  import modem_pkg::*;

  logic [SAMPLE_W-1:0] adc_q;  // input reclock, meant for the pad registers
  logic [SAMPLE_W-1:0] dac_q;

  always_ff @(posedge ck933) begin
    adc_q <= adc_d_i;
  end

  // two's complement to offset binary, flip the sign bit
  always_ff @(posedge ck933) begin
    dac_q <= {~adc_q[SAMPLE_W-1], adc_q[SAMPLE_W-2:0]};
  end

  assign dac0_d_o = dac_q;

endmodule

// File: logic/modem_top.sv
// board top level: connects the processor bus, register blocks, dac serial port and adc monitor to pins
`timescale 1ns/1ns

module modem_top (
  input  logic                            ck933,
  input  logic                            rs,
  input  logic                            cs_n_i,
  input  logic                            we_n_i,
  input  logic                            rd_n_i,
  input  logic [modem_pkg::ADDR_W-1:1]    addr_i,
  input  logic [modem_pkg::SAMPLE_W-1:0]  adc_d_i,
  inout  wire  [modem_pkg::DATA_W-1:0]    data_io,
  output logic                            dac_rst_o,
  output logic                            dac_sdio_o,
  output logic                            dac_sclk_o,
  output logic [modem_pkg::N_DAC-1:0]     dac_cs_n_o,
  output logic [modem_pkg::SAMPLE_W-1:0]  dac0_d_o,
  output logic                            bsync_n_lock_o,
  output logic                            demod_n_lock_o
);
  import modem_pkg::*;

  logic [DATA_W-1:0] rdata;
  logic [DATA_W-1:0] misc_rdata;
  logic [DATA_W-1:0] dac_rdata;
  logic              rd_en;
  logic              int_rs;
  logic [GPIO_W-1:0] gpio;

  host_bus_if bus ();

  // ******************************
  // processor bus
  // ******************************
  host_decode u_host_decode (
    .ck933        (ck933),
    .cs_n_i       (cs_n_i),
    .we_n_i       (we_n_i),
    .rd_n_i       (rd_n_i),
    .addr_i       (addr_i),
    .wdata_i      (data_io),
    .misc_rdata_i (misc_rdata),
    .dac_rdata_i  (dac_rdata),
    .rdata_o      (rdata),
    .rd_en_o      (rd_en),
    .bus          (bus.decoder)
  );

  assign data_io = rd_en ? rdata : {DATA_W{1'bz}}; // drive only during reads

  // version, software reset and lock leds
  misc_regs u_misc_regs (
    .ck933    (ck933),
    .rs       (rs),
    .bus      (bus.target),
    .rdata_o  (misc_rdata),
    .int_rs_o (int_rs),
    .gpio_o   (gpio)
  );

  assign dac_rst_o      = int_rs;
  assign bsync_n_lock_o = gpio[0];
  assign demod_n_lock_o = gpio[1];

  // ******************************
  // dac configuration and monitor
  // ******************************
  dac_serial_port u_dac_serial_port (
    .ck933    (ck933),
    .int_rs_i (int_rs),
    .bus      (bus.target),
    .rdata_o  (dac_rdata),
    .sclk_o   (dac_sclk_o),
    .sdio_o   (dac_sdio_o),
    .cs_n_o   (dac_cs_n_o)
  );

  adc_monitor u_adc_monitor (
    .ck933    (ck933),
    .adc_d_i  (adc_d_i),
    .dac0_d_o (dac0_d_o)
  );

endmodule

// File: verification/tb_modem.sv
// testbench for modem_top: runs a table of bus, serial and adc steps and checks the responses
`timescale 1ns/1ns

module tb_modem;
  import modem_pkg::*;

  typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_PINS, OP_SWRST, OP_SERIAL, OP_SERIAL_BUSY, OP_ADC
  } op_e;

  // addr holds the dac select for serial rows, data the sample count for adc rows
  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [DATA_W-1:0] expected;
  } row_t;

  localparam int CYCLES_PER_ROW = 100;

  logic                ck933 = 1'b0;
  logic                rs;
  logic                cs_n;
  logic                we_n;
  logic                rd_n;
  logic [ADDR_W-1:1]   addr;
  logic [SAMPLE_W-1:0] adc_d;
  logic [DATA_W-1:0]   drv_data;
  logic                drv_en;
  wire  [DATA_W-1:0]   data_io;
  logic                dac_rst;
  logic                dac_sdio;
  logic                dac_sclk;
  logic [N_DAC-1:0]    dac_cs_n;
  logic [SAMPLE_W-1:0] dac0_d;
  logic                bsync_lock;
  logic                demod_lock;

  row_t  rows [$];
  string names [$];
  int    checks = 0;
  int    errors = 0;
  int    cycle_cnt = 0;
  logic [DATA_W-1:0] sclk_word = '0;  // last 16 bits seen on sdio
  int    sclk_bits = 0;
  int    cs_low_cycles [N_DAC] = '{default: 0};

  assign data_io = drv_en ? drv_data : {DATA_W{1'bz}}; // host drives only on writes

  modem_top dut (
    .ck933          (ck933),
    .rs             (rs),
    .cs_n_i         (cs_n),
    .we_n_i         (we_n),
    .rd_n_i         (rd_n),
    .addr_i         (addr),
    .adc_d_i        (adc_d),
    .data_io        (data_io),
    .dac_rst_o      (dac_rst),
    .dac_sdio_o     (dac_sdio),
    .dac_sclk_o     (dac_sclk),
    .dac_cs_n_o     (dac_cs_n),
    .dac0_d_o       (dac0_d),
    .bsync_n_lock_o (bsync_lock),
    .demod_n_lock_o (demod_lock)
  );

  always #10 ck933 = ~ck933;

  // ******************************
  // serial monitor and watchdog
  // ******************************
  always @(posedge dac_sclk) begin
    if (dac_cs_n != '1) begin
      sclk_word = {sclk_word[DATA_W-2:0], dac_sdio}; // msb first
      sclk_bits++;
    end
  end

  always @(negedge ck933) begin
    for (int i = 0; i < N_DAC; i++) begin
      if (!dac_cs_n[i]) cs_low_cycles[i]++;
    end
  end

  always @(posedge ck933) begin
    cycle_cnt++;
    if (cycle_cnt > rows.size() * CYCLES_PER_ROW) begin
      $display("timeout: table not finished after %0d cycles", cycle_cnt);
      $display("** FAIL **");
      $finish;
    end
  end

  // ******************************
  // helpers
  // ******************************
  function automatic logic [ADDR_W-1:0] reg_addr(input logic [3:0] space,
                                                 input logic [REG_W-1:0] off);
    return {space, 4'h0, off, 1'b0};
  endfunction

  task automatic add_row(input string name, input op_e op, input logic [ADDR_W-1:0] a,
                         input logic [DATA_W-1:0] d, input logic [DATA_W-1:0] exp);
    names.push_back(name);
    rows.push_back('{op: op, addr: a, data: d, expected: exp});
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(posedge ck933);
    #2;
    cs_n     = 1'b0;
    we_n     = 1'b0;
    addr     = a[ADDR_W-1:1];
    drv_data = d;
    drv_en   = 1'b1;
    @(posedge ck933);  // write taken here
    #2;
    cs_n   = 1'b1;
    we_n   = 1'b1;
    drv_en = 1'b0;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    @(posedge ck933);
    #2;
    cs_n = 1'b0;
    rd_n = 1'b0;
    addr = a[ADDR_W-1:1];
    @(negedge ck933);  // combinational read, settled by mid cycle
    d = data_io;
    @(posedge ck933);
    #2;
    cs_n = 1'b1;
    rd_n = 1'b1;
  endtask

  task automatic check_reset_stretch(input string name, input int min_cycles);
    int high_cycles;
    high_cycles = 0;
    bus_write(reg_addr(MISC, REG_RESET), '0);
    @(negedge ck933);
    while (dac_rst) begin
      high_cycles++;
      @(negedge ck933);
    end
    checks++;
    assert (high_cycles >= min_cycles) else begin
      $display("%s: dac reset high for %0d cycles, needs at least %0d", name, high_cycles,
               min_cycles);
      errors++;
    end
  endtask

  task automatic run_serial(input string name, input logic [SEL_W-1:0] sel,
                            input logic [N_DAC-1:0] exp_cs, input bit send_twice);
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] status;
    logic [N_DAC-1:0]  seen_cs;
    int                bits_before;
    int                low_before [N_DAC];
    word = DATA_W'($urandom);
    bus_write(reg_addr(DAC_SER, REG_DAC_CTRL), DATA_W'(sel));
    bits_before = sclk_bits;
    for (int i = 0; i < N_DAC; i++) low_before[i] = cs_low_cycles[i];
    bus_write(reg_addr(DAC_SER, REG_DAC_WORD), word);
    bus_read(reg_addr(DAC_SER, REG_DAC_CTRL), status);
    check_value({name, " busy"}, 1, status[DATA_W-1]);
    if (send_twice) bus_write(reg_addr(DAC_SER, REG_DAC_WORD), ~word); // must be dropped
    do begin
      bus_read(reg_addr(DAC_SER, REG_DAC_CTRL), status);
    end while (status[DATA_W-1]);
    check_value({name, " select"}, sel, status[SEL_W-1:0]);
    check_value({name, " bit count"}, DAC_BITS, sclk_bits - bits_before);
    check_value({name, " word"}, word, sclk_word);
    for (int i = 0; i < N_DAC; i++) seen_cs[i] = (cs_low_cycles[i] != low_before[i]);
    check_value({name, " chip select"}, exp_cs, seen_cs);
    check_value({name, " select low cycles"}, DAC_BITS * SCLK_DIV,
                cs_low_cycles[sel] - low_before[sel]);
  endtask

  task automatic run_adc(input string name, input int n);
    logic [SAMPLE_W-1:0] sent [$];
    logic [SAMPLE_W-1:0] want;
    for (int k = 0; k < n + 2; k++) begin
      @(posedge ck933);
      #2;
      if (k < n) begin
        adc_d = SAMPLE_W'($urandom);
        sent.push_back(adc_d);
      end
      @(negedge ck933);
      if (k >= 2) begin  // sample k-2 has passed both registers
        want = sent[k-2];
        want[SAMPLE_W-1] = ~want[SAMPLE_W-1];
        check_value(name, want, dac0_d);
      end
    end
  endtask

  task automatic run_row(input string name, input row_t row);
    logic [DATA_W-1:0] rd;
    case (row.op)
      OP_WRITE: bus_write(row.addr, row.data);
      OP_READ: begin
        bus_read(row.addr, rd);
        check_value(name, row.expected, rd);
      end
      OP_PINS: begin
        @(negedge ck933);
        check_value(name, row.expected, {demod_lock, bsync_lock});
      end
      OP_SWRST:       check_reset_stretch(name, row.expected);
      OP_SERIAL:      run_serial(name, row.addr[SEL_W-1:0], row.expected[N_DAC-1:0], 1'b0);
      OP_SERIAL_BUSY: run_serial(name, row.addr[SEL_W-1:0], row.expected[N_DAC-1:0], 1'b1);
      default:        run_adc(name, row.data);
    endcase
  endtask

  // ******************************
  // stimulus table and main flow
  // ******************************
  initial begin
    rs       = 1'b1;
    cs_n     = 1'b1;
    we_n     = 1'b1;
    rd_n     = 1'b1;
    addr     = '0;
    adc_d    = '0;
    drv_data = '0;
    drv_en   = 1'b0;
    void'($urandom(32'hb14748ac));

    add_row("pins_after_por",   OP_PINS,   '0, '0, 16'h0000);
    add_row("version",          OP_READ,   reg_addr(MISC, REG_VERSION), '0, 16'h0003);
    add_row("unmapped_low",     OP_READ,   reg_addr(4'd3, 3'd0), '0, 16'h0000);
    add_row("unmapped_high",    OP_READ,   reg_addr(4'd11, 3'd1), '0, 16'h0000);
    add_row("gpio_write_1",     OP_WRITE,  reg_addr(GPIO, REG_GPIO), 16'h0001, '0);
    add_row("gpio_pins_1",      OP_PINS,   '0, '0, 16'h0001);
    add_row("gpio_read_1",      OP_READ,   reg_addr(GPIO, REG_GPIO), '0, 16'h0001);
    add_row("gpio_write_2",     OP_WRITE,  reg_addr(GPIO, REG_GPIO), 16'hfffe, '0);
    add_row("gpio_pins_2",      OP_PINS,   '0, '0, 16'h0002);
    add_row("gpio_write_3",     OP_WRITE,  reg_addr(GPIO, REG_GPIO), 16'h0003, '0);
    add_row("gpio_read_3",      OP_READ,   reg_addr(GPIO, REG_GPIO), '0, 16'h0003);
    add_row("sw_reset",         OP_SWRST,  '0, '0, 16'(RESET_HOLD));
    add_row("gpio_after_reset", OP_READ,   reg_addr(GPIO, REG_GPIO), '0, 16'h0000);
    add_row("pins_after_reset", OP_PINS,   '0, '0, 16'h0000);
    add_row("serial_dac0",      OP_SERIAL, 12'd0, '0, 16'b001);
    add_row("serial_dac1",      OP_SERIAL, 12'd1, '0, 16'b010);
    add_row("serial_dac2",      OP_SERIAL, 12'd2, '0, 16'b100);
    add_row("serial_busy_drop", OP_SERIAL_BUSY, 12'd1, '0, 16'b010);
    add_row("adc_monitor",      OP_ADC,    '0, 16'd24, '0);

    repeat (16) @(posedge ck933);
    #2;
    rs = 1'b0;

    for (int r = 0; r < rows.size(); r++) run_row(names[r], rows[r]);

    @(posedge ck933);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/modem_pkg.sv
logic/host_bus_if.sv
logic/host_decode.sv
logic/misc_regs.sv
logic/dac_serial_port.sv
logic/adc_monitor.sv
logic/modem_top.sv
verification/tb_modem.sv

// File: Makefile
TOP = tb_modem

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, fail on a failing run"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP) > sim.log 2>&1 || echo "** FAIL **" >> sim.log
	@cat sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "test failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
